// File: verilog/cpuPkg.sv
// Core shared definitions
`default_nettype none

package cpuPkg;

    // Plain vector types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIndex_t;

    // Instruction type codes, anything else runs as a no-op
    typedef enum logic [4:0] {
        OpRType = 5'd0,
        OpJ     = 5'd1,
        OpBne   = 5'd2,
        OpJal   = 5'd3,
        OpJr    = 5'd4,
        OpAddi  = 5'd5,
        OpBlt   = 5'd6,
        OpSw    = 5'd7,
        OpLw    = 5'd8
    } opcode_t;

    // R-type function codes
    typedef enum logic [4:0] {
        AluAdd = 5'd0,
        AluSub = 5'd1,
        AluAnd = 5'd2,
        AluOr  = 5'd3,
        AluSll = 5'd4,
        AluSra = 5'd5
    } aluOp_t;

    // jal destination
    localparam regIndex_t LinkReg = 5'd31;

    ////////////////////////////////////////
    // Instruction field positions
    ////////////////////////////////////////
    localparam int OpcodeHi = 31;
    localparam int OpcodeLo = 27;
    localparam int RdHi     = 26;
    localparam int RdLo     = 22;
    localparam int RsHi     = 21;
    localparam int RsLo     = 17;
    localparam int RtHi     = 16;
    localparam int RtLo     = 12;
    localparam int ShamtHi  = 11;
    localparam int ShamtLo  = 7;
    localparam int AluOpHi  = 6;
    localparam int AluOpLo  = 2;
    // 17-bit immediate, sign-extended on use
    localparam int ImmHi    = 16;
    localparam int ImmLo    = 0;
    localparam int TargetHi = 26;
    localparam int TargetLo = 0;

    ////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////
    typedef struct packed {
        word_t instruction;
        word_t pcNext;
    } fdReg_t;

    typedef struct packed {
        fdReg_t fd;
        word_t  rsData;
        word_t  rtData;
    } dxReg_t;

    typedef struct packed {
        word_t instruction;
        word_t result;
        word_t storeData;
    } xmReg_t;

    typedef struct packed {
        word_t instruction;
        word_t result;
        word_t loadData;
    } mwReg_t;

    // Data memory request, write lands on the rising edge
    typedef struct packed {
        word_t address;
        word_t writeData;
        logic  writeEnable;
    } dmemReq_t;

endpackage

`default_nettype wire

// File: verilog/fetchStage.sv
// Instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

module fetchStage import cpuPkg::*; #(
    parameter int ImemAddrWidth = 12
) (
    input  wire logic  clock,
    input  wire logic  reset,
    input  wire word_t imemData,
    input  wire logic  loadUseStall,
    input  wire logic  redirectValid,
    input  wire word_t redirectTarget,
    output word_t      imemAddress,
    output fdReg_t     fd
);

    word_t pc;
    word_t pcPlusOne;
    word_t pcNext;

    // Word addressed, so sequential fetch is plus one
    assign pcPlusOne = pc + 32'd1;

    // Taken jump or branch wins, a stall holds the PC
    always_comb begin
        if (redirectValid) begin
            pcNext = redirectTarget;
        end else if (loadUseStall) begin
            pcNext = pc;
        end else begin
            pcNext = pcPlusOne;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // Only the low bits reach the instruction memory
    assign imemAddress = {{(32 - ImemAddrWidth){1'b0}}, pc[ImemAddrWidth-1:0]};

    ////////////////////////////////////////
    // Fetch/decode register
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset || redirectValid) begin
            // Younger fetch is dropped on a redirect
            fd <= '0;
        end else if (!loadUseStall) begin
            fd.instruction <= imemData;
            fd.pcNext      <= pcPlusOne;
        end
    end

    // Stalled cycle leaves the PC in place
    assert property (@(posedge clock) disable iff (reset) loadUseStall |=> $stable(pc))
        else $error("PC advanced during a load-use stall");

endmodule

`default_nettype wire

// File: verilog/decodeStage.sv
// Instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module decodeStage import cpuPkg::*; (
    input  wire logic   clock,
    input  wire logic   reset,
    input  wire fdReg_t fd,
    input  wire word_t  readDataA,
    input  wire word_t  readDataB,
    input  wire logic   squash,
    input  wire word_t  dxInstruction,
    output regIndex_t   readRegA,
    output regIndex_t   readRegB,
    output logic        loadUseStall,
    output dxReg_t      dx
);

    opcode_t   opcode;
    regIndex_t rd;
    regIndex_t rs;
    regIndex_t rt;
    logic      readsRd;

    // Fields of the instruction in execute
    opcode_t   dxOpcode;
    regIndex_t dxRd;

    assign opcode = opcode_t'(fd.instruction[OpcodeHi:OpcodeLo]);
    assign rd     = fd.instruction[RdHi:RdLo];
    assign rs     = fd.instruction[RsHi:RsLo];
    assign rt     = fd.instruction[RtHi:RtLo];

    // Branches, jr and sw take their second source from rd
    assign readsRd = (opcode == OpBne) || (opcode == OpJr) ||
                     (opcode == OpBlt) || (opcode == OpSw);

    assign readRegA = rs;
    assign readRegB = readsRd ? rd : rt;

    ////////////////////////////////////////
    // Load-use hazard
    ////////////////////////////////////////
    // Fields of the lw candidate sitting in execute
    assign dxOpcode = opcode_t'(dxInstruction[OpcodeHi:OpcodeLo]);
    assign dxRd     = dxInstruction[RdHi:RdLo];

    // Store data of a sw is fixed up later in the memory stage
    always_comb begin
        loadUseStall = 1'b0;
        if (dxOpcode == OpLw) begin
            if (rs == dxRd) begin
                loadUseStall = 1'b1;
            end
            if ((readRegB == dxRd) && (opcode != OpSw)) begin
                loadUseStall = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Decode/execute register
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset || squash || loadUseStall) begin
            // Bubble in place of the held or discarded entry
            dx <= '0;
        end else begin
            dx.fd     <= fd;
            dx.rsData <= readDataA;
            dx.rtData <= readDataB;
        end
    end

endmodule

`default_nettype wire

// File: verilog/executeStage.sv
// Execute stage with bypass and ALU
`timescale 1ns/1ps
`default_nettype none

module executeStage import cpuPkg::*; (
    input  wire logic   clock,
    input  wire logic   reset,
    input  wire dxReg_t dx,
    input  wire word_t  memResult,
    input  wire word_t  memInstruction,
    input  wire word_t  wbData,
    input  wire word_t  wbInstruction,
    output logic        redirectValid,
    output word_t       redirectTarget,
    output xmReg_t      xm
);

    opcode_t   opcode;
    aluOp_t    aluOp;
    regIndex_t rd;
    regIndex_t rs;
    regIndex_t rt;
    logic [4:0] shamt;
    word_t     immediate;
    word_t     jumpTarget;
    logic      readsRd;
    logic      usesImmediate;
    word_t     operandA;
    word_t     operandB;
    word_t     aluIn;
    word_t     aluResult;
    logic      isControl;

    // Register written by an older instruction
    function automatic regIndex_t destOf(input word_t instr);
        // jal writes the link register
        if (opcode_t'(instr[OpcodeHi:OpcodeLo]) == OpJal) begin
            return LinkReg;
        end
        return instr[RdHi:RdLo];
    endfunction

    // Bypass hit from an older writing instruction to a nonzero register
    function automatic logic hits(input word_t instr, input regIndex_t src);
        opcode_t op;
        op = opcode_t'(instr[OpcodeHi:OpcodeLo]);
        return (op inside {OpRType, OpAddi, OpLw, OpJal}) &&
               (destOf(instr) != '0) && (destOf(instr) == src);
    endfunction

    // Memory stage holds the younger result and wins over writeback
    function automatic word_t pickOperand(input regIndex_t src, input word_t regValue);
        if (hits(memInstruction, src)) begin
            return memResult;
        end else if (hits(wbInstruction, src)) begin
            return wbData;
        end
        return regValue;
    endfunction

    ////////////////////////////////////////
    // Field decode
    ////////////////////////////////////////
    assign opcode     = opcode_t'(dx.fd.instruction[OpcodeHi:OpcodeLo]);
    assign aluOp      = aluOp_t'(dx.fd.instruction[AluOpHi:AluOpLo]);
    assign rd         = dx.fd.instruction[RdHi:RdLo];
    assign rs         = dx.fd.instruction[RsHi:RsLo];
    assign rt         = dx.fd.instruction[RtHi:RtLo];
    assign shamt      = dx.fd.instruction[ShamtHi:ShamtLo];
    assign immediate  = {{15{dx.fd.instruction[ImmHi]}}, dx.fd.instruction[ImmHi:ImmLo]};
    assign jumpTarget = {5'b0, dx.fd.instruction[TargetHi:TargetLo]};

    assign readsRd       = opcode inside {OpBne, OpJr, OpBlt, OpSw};
    assign usesImmediate = opcode inside {OpAddi, OpLw, OpSw};

    // Operand B follows whichever register decode read on port B
    always_comb begin
        operandA = pickOperand(rs, dx.rsData);
        operandB = pickOperand(readsRd ? rd : rt, dx.rtData);
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    assign aluIn = usesImmediate ? immediate : operandB;

    always_comb begin
        if (opcode != OpRType) begin
            // Address and addi arithmetic
            aluResult = operandA + aluIn;
        end else begin
            unique case (aluOp)
                AluAdd:  aluResult = operandA + aluIn;
                AluSub:  aluResult = operandA - aluIn;
                AluAnd:  aluResult = operandA & aluIn;
                AluOr:   aluResult = operandA | aluIn;
                AluSll:  aluResult = operandA << shamt;
                AluSra:  aluResult = word_t'($signed(operandA) >>> shamt);
                default: aluResult = '0;
            endcase
        end
    end

    // Branches compare rd against rs
    always_comb begin
        redirectValid  = 1'b0;
        redirectTarget = dx.fd.pcNext + immediate;
        unique case (opcode)
            OpBne: redirectValid = (operandB != operandA);
            OpBlt: redirectValid = ($signed(operandB) < $signed(operandA));
            OpJ, OpJal: begin
                redirectValid  = 1'b1;
                redirectTarget = jumpTarget;
            end
            OpJr: begin
                redirectValid  = 1'b1;
                redirectTarget = operandB;
            end
            default: redirectValid = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            xm <= '0;
        end else begin
            xm.instruction <= dx.fd.instruction;
            // Link value for jal
            xm.result      <= (opcode == OpJal) ? dx.fd.pcNext : aluResult;
            xm.storeData   <= operandB;
        end
    end

    assign isControl = opcode inside {OpJ, OpBne, OpJal, OpJr, OpBlt};

    // A redirect only comes from a control instruction
    assert property (@(posedge clock) disable iff (reset) redirectValid |-> isControl)
        else $error("Redirect from a non-control instruction");

    // The entry behind a redirect is squashed to a bubble
    assert property (@(posedge clock) disable iff (reset)
        redirectValid |=> (dx.fd.instruction == '0))
        else $error("Redirect without squash of the next entry");

endmodule

`default_nettype wire

// File: verilog/memWriteStage.sv
// Memory access and writeback
`timescale 1ns/1ps
`default_nettype none

module memWriteStage import cpuPkg::*; #(
    parameter int DmemAddrWidth = 12
) (
    input  wire logic   clock,
    input  wire logic   reset,
    input  wire xmReg_t xm,
    input  wire word_t  dmemData,
    output dmemReq_t    dmem,
    output logic        writeEnable,
    output regIndex_t   writeReg,
    output word_t       writeData,
    output word_t       wbInstruction
);

    opcode_t   xmOpcode;
    regIndex_t xmRd;
    opcode_t   wbOpcode;
    mwReg_t    mw;

    assign xmOpcode = opcode_t'(xm.instruction[OpcodeHi:OpcodeLo]);
    assign xmRd     = xm.instruction[RdHi:RdLo];

    ////////////////////////////////////////
    // Data memory drive
    ////////////////////////////////////////
    assign dmem.address = {{(32 - DmemAddrWidth){1'b0}}, xm.result[DmemAddrWidth-1:0]};
    assign dmem.writeEnable = (xmOpcode == OpSw);

    // Writeback of the previous instruction overrides stale store data
    assign dmem.writeData = (writeEnable && (writeReg == xmRd)) ? writeData : xm.storeData;

    always_ff @(posedge clock) begin
        if (reset) begin
            mw <= '0;
        end else begin
            mw.instruction <= xm.instruction;
            mw.result      <= xm.result;
            mw.loadData    <= dmemData;
        end
    end

    ////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////
    assign wbOpcode      = opcode_t'(mw.instruction[OpcodeHi:OpcodeLo]);
    assign wbInstruction = mw.instruction;

    assign writeData = (wbOpcode == OpLw) ? mw.loadData : mw.result;
    assign writeReg  = (wbOpcode == OpJal) ? LinkReg : mw.instruction[RdHi:RdLo];

    // Register 0 is never written, which keeps bubbles silent
    assign writeEnable = (wbOpcode inside {OpRType, OpAddi, OpLw, OpJal}) &&
                         (writeReg != '0);

    // A store reaching writeback must not touch the register file
    assert property (@(posedge clock) disable iff (reset) dmem.writeEnable |=> !writeEnable)
        else $error("Store also wrote a register");

endmodule

`default_nettype wire

// File: verilog/pipelineCpu.sv
// Pipelined core top level
`timescale 1ns/1ps
`default_nettype none

module pipelineCpu import cpuPkg::*; #(
    parameter int ImemAddrWidth = 12,
    parameter int DmemAddrWidth = 12
) (
    input  wire logic      clock,
    input  wire logic      reset,
    // Instruction memory
    output word_t          imemAddress,
    input  wire word_t     imemData,
    // Data memory
    output dmemReq_t       dmem,
    input  wire word_t     dmemData,
    // Register file
    output regIndex_t      readRegA,
    output regIndex_t      readRegB,
    input  wire word_t     readDataA,
    input  wire word_t     readDataB,
    output logic           writeEnable,
    output regIndex_t      writeReg,
    output word_t          writeData
);

    // Stage to stage buses
    fdReg_t fdBus;
    dxReg_t dxBus;
    xmReg_t xmBus;

    // Hazard and redirect control
    logic  loadUseStall;
    logic  redirectValid;
    word_t redirectTarget;
    word_t wbInstruction;

    fetchStage #(.ImemAddrWidth(ImemAddrWidth)) fetch_i (
        .clock          (clock),
        .reset          (reset),
        .imemData       (imemData),
        .loadUseStall   (loadUseStall),
        .redirectValid  (redirectValid),
        .redirectTarget (redirectTarget),
        .imemAddress    (imemAddress),
        .fd             (fdBus)
    );

    decodeStage decode_i (
        .clock         (clock),
        .reset         (reset),
        .fd            (fdBus),
        .readDataA     (readDataA),
        .readDataB     (readDataB),
        .squash        (redirectValid),
        .dxInstruction (dxBus.fd.instruction),
        .readRegA      (readRegA),
        .readRegB      (readRegB),
        .loadUseStall  (loadUseStall),
        .dx            (dxBus)
    );

    // Bypass sources are the memory stage entry and the writeback value
    executeStage execute_i (
        .clock          (clock),
        .reset          (reset),
        .dx             (dxBus),
        .memResult      (xmBus.result),
        .memInstruction (xmBus.instruction),
        .wbData         (writeData),
        .wbInstruction  (wbInstruction),
        .redirectValid  (redirectValid),
        .redirectTarget (redirectTarget),
        .xm             (xmBus)
    );

    memWriteStage #(.DmemAddrWidth(DmemAddrWidth)) memWrite_i (
        .clock         (clock),
        .reset         (reset),
        .xm            (xmBus),
        .dmemData      (dmemData),
        .dmem          (dmem),
        .writeEnable   (writeEnable),
        .writeReg      (writeReg),
        .writeData     (writeData),
        .wbInstruction (wbInstruction)
    );

endmodule

`default_nettype wire

// File: bench/benchSystem.sv
// Memory and register file models
`timescale 1ns/1ps
`default_nettype none

module benchSystem import cpuPkg::*; #(
    parameter int ImemAddrWidth = 12,
    parameter int DmemAddrWidth = 12
) (
    input  wire logic clock,
    input  wire logic reset,
    // Write events for the checker
    output logic      regWriteEnable,
    output regIndex_t regWriteIndex,
    output word_t     regWriteData,
    output logic      storeEnable,
    output word_t     storeAddress,
    output word_t     storeData
);

    localparam int ImemWords = 1 << ImemAddrWidth;
    localparam int DmemWords = 1 << DmemAddrWidth;

    // Program words are loaded in from the testbench during reset
    word_t imem [ImemWords] = '{default: '0};
    word_t dmemArray [DmemWords] = '{default: '0};
    word_t regFile [32] = '{default: '0};

    word_t     imemAddress;
    word_t     imemData;
    dmemReq_t  dmem;
    word_t     dmemData;
    regIndex_t readRegA;
    regIndex_t readRegB;
    word_t     readDataA;
    word_t     readDataB;
    logic      writeEnable;
    regIndex_t writeReg;
    word_t     writeData;

    pipelineCpu #(
        .ImemAddrWidth (ImemAddrWidth),
        .DmemAddrWidth (DmemAddrWidth)
    ) dut_i (
        .clock       (clock),
        .reset       (reset),
        .imemAddress (imemAddress),
        .imemData    (imemData),
        .dmem        (dmem),
        .dmemData    (dmemData),
        .readRegA    (readRegA),
        .readRegB    (readRegB),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .writeEnable (writeEnable),
        .writeReg    (writeReg),
        .writeData   (writeData)
    );

    ////////////////////////////////////////
    // Asynchronous reads
    ////////////////////////////////////////
    assign imemData = imem[imemAddress[ImemAddrWidth-1:0]];
    assign dmemData = dmemArray[dmem.address[DmemAddrWidth-1:0]];

    // Write-through, so decode sees the value leaving writeback this cycle
    assign readDataA = (writeEnable && (writeReg == readRegA)) ? writeData : regFile[readRegA];
    assign readDataB = (writeEnable && (writeReg == readRegB)) ? writeData : regFile[readRegB];

    // Both writes land on the rising edge
    always @(posedge clock) begin
        if (dmem.writeEnable) begin
            dmemArray[dmem.address[DmemAddrWidth-1:0]] <= dmem.writeData;
        end
        if (writeEnable) begin
            regFile[writeReg] <= writeData;
        end
    end

    // Event taps
    assign regWriteEnable = writeEnable;
    assign regWriteIndex  = writeReg;
    assign regWriteData   = writeData;
    assign storeEnable    = dmem.writeEnable;
    assign storeAddress   = dmem.address;
    assign storeData      = dmem.writeData;

endmodule

`default_nettype wire

// File: bench/pipelineCpuTb.sv
// Pipelined core testbench
`timescale 1ns/1ps
`default_nettype none

module pipelineCpuTb import cpuPkg::*; ();

    localparam int    ImemAddrWidth = 12;
    localparam int    DmemAddrWidth = 12;
    localparam int    ClockHalf     = 20;
    localparam int    DriveDelay    = 2;
    localparam int    ResetCycles   = 10;
    localparam int    TailCycles    = 20;
    localparam int    CyclesPerWord = 8;
    localparam int    SlackCycles   = 200;
    localparam string StimulusFile  = "bench/programInput.txt";

    logic      clock;
    logic      reset;
    logic      regWriteEnable;
    regIndex_t regWriteIndex;
    word_t     regWriteData;
    logic      storeEnable;
    word_t     storeAddress;
    word_t     storeData;

    // Program and the expected write events in program order
    word_t      programWords [$];
    logic [7:0] expKind [$];
    word_t      expKey [$];
    word_t      expValue [$];

    int   expCount;
    int   nextExpected;
    int   errorCount;
    int   extraCount;
    int   missingCount;
    logic sampling = 1'b0;
    logic stimulusRead = 1'b0;

    benchSystem #(
        .ImemAddrWidth (ImemAddrWidth),
        .DmemAddrWidth (DmemAddrWidth)
    ) system_i (
        .clock          (clock),
        .reset          (reset),
        .regWriteEnable (regWriteEnable),
        .regWriteIndex  (regWriteIndex),
        .regWriteData   (regWriteData),
        .storeEnable    (storeEnable),
        .storeAddress   (storeAddress),
        .storeData      (storeData)
    );

    always #ClockHalf clock = ~clock;

    task automatic checkValue(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s: expected %08h, actual %08h at %0t", name, expected, actual, $time);
        end
    endtask

    function automatic string kindName(input logic [7:0] kind);
        return (kind == "W") ? "register write" : "store";
    endfunction

    ////////////////////////////////////////
    // Stimulus file
    ////////////////////////////////////////
    // Only lines tagged I, W or S are kept
    task automatic readStimulus();
        int         fd;
        int         fields;
        string      line;
        logic [7:0] tag;
        word_t      first;
        word_t      second;
        fd = $fopen(StimulusFile, "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open the stimulus file %s", StimulusFile);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            tag  = 8'h00;
            if ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%c %h %h", tag, first, second);
                if ((tag == "I") && (fields >= 2)) begin
                    programWords.push_back(first);
                end else if (((tag == "W") || (tag == "S")) && (fields == 3)) begin
                    expKind.push_back(tag);
                    expKey.push_back(first);
                    expValue.push_back(second);
                end
            end
        end
        $fclose(fd);
        if (expKind.size() == 0) begin
            errorCount++;
            $display("The stimulus file holds no expected events");
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < programWords.size(); i++) begin
            system_i.imem[i[ImemAddrWidth-1:0]] = programWords[i];
        end
    endtask

    // Compares one observed write with the next expected record
    task automatic observeEvent(input logic [7:0] kind, input word_t key, input word_t value);
        string keyName;
        string valueName;
        keyName   = (kind == "W") ? "writeReg" : "dmem.address";
        valueName = (kind == "W") ? "writeData" : "dmem.writeData";
        if (nextExpected >= expCount) begin
            extraCount++;
            $display("Unexpected %s at %0t after the last expected event", kindName(kind), $time);
        end else begin
            if (expKind[nextExpected] != kind) begin
                errorCount++;
                $display("Event %0d out of order: expected a %s but saw a %s at %0t",
                         nextExpected, kindName(expKind[nextExpected]), kindName(kind), $time);
            end else begin
                checkValue(keyName, expKey[nextExpected], key);
                checkValue(valueName, expValue[nextExpected], value);
            end
            nextExpected++;
        end
    endtask

    task automatic printCounts();
        $display("Events seen %0d of %0d, errors %0d, extra %0d, missing %0d",
                 nextExpected, expCount, errorCount, extraCount, missingCount);
    endtask

    ////////////////////////////////////////
    // Event sampling
    ////////////////////////////////////////
    // The writes of the coming rising edge are stable at the falling edge
    always @(negedge clock) begin
        if (sampling) begin
            // Writeback holds the older instruction and goes first
            if (regWriteEnable === 1'b1) begin
                if (regWriteIndex == '0) begin
                    errorCount++;
                    $display("A write to register 0 was asserted at %0t", $time);
                end
                observeEvent("W", {27'b0, regWriteIndex}, regWriteData);
            end
            if (storeEnable === 1'b1) begin
                observeEvent("S", storeAddress, storeData);
            end
        end
    end

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        errorCount   = 0;
        extraCount   = 0;
        missingCount = 0;
        nextExpected = 0;
        readStimulus();
        expCount     = expKind.size();
        stimulusRead = 1'b1;
        @(posedge clock);
        #DriveDelay;
        loadProgram();
        sampling = 1'b1;
        repeat (ResetCycles - 1) @(posedge clock);
        #DriveDelay;
        reset = 1'b0;
        wait (nextExpected == expCount);
        // Program parks in a self jump and writes nothing more
        repeat (TailCycles) @(posedge clock);
        printCounts();
        if ((errorCount == 0) && (extraCount == 0)) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin : watchdog
        int limit;
        wait (stimulusRead);
        limit = CyclesPerWord * programWords.size() + SlackCycles;
        repeat (limit) @(posedge clock);
        missingCount = expCount - nextExpected;
        $display("Timeout after %0d cycles, the program never produced all expected events",
                 limit);
        printCounts();
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/programInput.txt
# I word : program word in hex, placed from address 0 upward
# W reg value : expected register write, S addr value : expected store, in program order, hex
I 28400005  # 0  addi r1, r0, 5
I 2883FFFD  # 1  addi r2, r1, -3
I 00C22000  # 2  add  r3, r1, r2
I 01061004  # 3  sub  r4, r3, r1
I 01483008  # 4  and  r5, r4, r3
I 018A100C  # 5  or   r6, r5, r1
I 01CC0210  # 6  sll  r7, r6, 4
I 02007004  # 7  sub  r8, r0, r7
I 02500114  # 8  sra  r9, r8, 2
I 3A420002  # 9  sw   r9, 2(r1)
I 28120001  # 10 addi r0, r9, 1
I 42820002  # 11 lw   r10, 2(r1)
I 2AD40020  # 12 addi r11, r10, 0x20
I 43020002  # 13 lw   r12, 2(r1)
I 0342C000  # 14 add  r13, r1, r12
I 12C20002  # 15 bne  r11, r1, +2
I 2D000001  # 16 addi r20, r0, 1
I 2D000002  # 17 addi r20, r0, 2
I 30560002  # 18 blt  r1, r11, +2
I 2B800003  # 19 addi r14, r0, 3
I 2BDE0002  # 20 addi r15, r15, 2
I 2B9DFFFF  # 21 addi r14, r14, -1
I 301DFFFD  # 22 blt  r0, r14, -3
I 2D400009  # 23 addi r21, r0, 9
I 1800001C  # 24 jal  28
I 2D800011  # 25 addi r22, r0, 0x11
I 0800001F  # 26 j    31
I 2DC00055  # 27 addi r23, r0, 0x55
I 2E3E0000  # 28 addi r24, r31, 0
I 27C00000  # 29 jr   r31
I 2E400001  # 30 addi r25, r0, 1
I 0800001F  # 31 j    31
W 01 00000005
W 02 00000002
W 03 00000007
W 04 00000002
W 05 00000002
W 06 00000007
W 07 00000070
W 08 FFFFFF90
W 09 FFFFFFE4
S 00000007 FFFFFFE4
W 0A FFFFFFE4
W 0B 00000004
W 0C FFFFFFE4
W 0D FFFFFFE9
W 0E 00000003
W 0F 00000002
W 0E 00000002
W 0F 00000004
W 0E 00000001
W 0F 00000006
W 0E 00000000
W 15 00000009
W 1F 00000019
W 18 00000019
W 16 00000011

// File: pipelineCpu.f
verilog/cpuPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWriteStage.sv
verilog/pipelineCpu.sv
bench/benchSystem.sv
bench/pipelineCpuTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the pipelined core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module pipelineCpuTb -f pipelineCpu.f -o pipelineCpuSim
output="$(./obj_dir/pipelineCpuSim)"
echo "$output"
if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
